//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_rv_core
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --timescale 1ns/1ps -Wno-fatal
SIMFLAGS ?= +verilator+error+limit+1000
PASS_MSG ?= Regression passed

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --assert $(VFLAGS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIMFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- rv_core.sv
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module rv_core
    import rv_core_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        inst_valid_i,
    input  inst_width_t inst_i,
    output logic        inst_ready_o,
    output logic        retire_valid_o,
    output retire_t     retire_o
);

// --------------------
// reset sequence
logic [`PIPE_STAGES-1:0] reset_seq;
logic flush_dec;
logic flush_exe;
logic flush_wbk;
logic ready_q;

// ones drain out from the DEC end first
always_ff @(posedge clk) begin
    if (rst) begin
        reset_seq <= '1;
        ready_q <= 1'b0;
    end else begin
        reset_seq <= {reset_seq[`PIPE_STAGES-2:0], 1'b0};
        // rises together with reset_seq reaching zero
        ready_q <= (reset_seq[`PIPE_STAGES-2:0] == '0);
    end
end

assign flush_dec = reset_seq[0];
assign flush_exe = reset_seq[1];
assign flush_wbk = reset_seq[`PIPE_STAGES-1];

// pipeline never stalls once out of reset
assign inst_ready_o = ready_q;

// --------------------
// DEC stage
logic accept;
logic valid_dec;
inst_width_t inst_dec;
decoded_t decoded_dec;
arch_width_t rs1_data_dec;
arch_width_t rs2_data_dec;
arch_width_t op_b_dec;

assign accept = inst_valid_i && inst_ready_o;

always_ff @(posedge clk) begin
    if (accept) begin
        inst_dec <= inst_i;
    end
    // idle input turns into a bubble
    if (flush_dec) begin
        valid_dec <= 1'b0;
    end else begin
        valid_dec <= accept;
    end
end

rv_decoder rv_decoder_i (
    .inst_i    (inst_dec),
    .decoded_o (decoded_dec)
);

retire_t wbk_q;
logic valid_wbk;

rv_reg_file rv_reg_file_i (
    .clk        (clk),
    .rs1_i      (decoded_dec.rs1),
    .rs2_i      (decoded_dec.rs2),
    .wr_i       (wbk_q),
    .wr_valid_i (valid_wbk),
    .rs1_data_o (rs1_data_dec),
    .rs2_data_o (rs2_data_dec)
);

assign op_b_dec = (decoded_dec.b_sel == B_SEL_IMM) ? decoded_dec.imm : rs2_data_dec;

// --------------------
// EXE stage
exe_stage_t exe_q;
retire_t result_exe;
arch_width_t minstret;

always_ff @(posedge clk) begin
    exe_q.decoded <= decoded_dec;
    exe_q.op_a <= rs1_data_dec;
    exe_q.op_b <= op_b_dec;
    if (flush_exe) begin
        exe_q.valid <= 1'b0;
    end else begin
        exe_q.valid <= valid_dec;
    end
end

rv_execute rv_execute_i (
    .stage_i     (exe_q),
    .wbk_i       (wbk_q),
    .wbk_valid_i (valid_wbk),
    .csr_data_i  (minstret),
    .result_o    (result_exe)
);

// --------------------
// WBK stage and retire
always_ff @(posedge clk) begin
    wbk_q <= result_exe;
    if (flush_wbk) begin
        valid_wbk <= 1'b0;
    end else begin
        valid_wbk <= exe_q.valid;
    end
end

rv_retire_counter rv_retire_counter_i (
    .clk            (clk),
    .rst            (rst),
    .retire_valid_i (valid_wbk),
    .count_o        (minstret)
);

assign retire_valid_o = valid_wbk;
assign retire_o = wbk_q;

endmodule

//--- rv_core_checker.sv
`timescale 1ns/1ps

module rv_core_checker
    import rv_core_pkg::*;
(
    input logic    clk,
    input logic    rst,
    input logic    inst_valid_i,
    input logic    inst_ready_o,
    input logic    retire_valid_o,
    input retire_t retire_o
);

int assert_failures = 0;
logic rst_d;
logic [2:0] accept_hist;
logic [1:0] since_rst;

// --------------------
// history of accepted instructions
always_ff @(posedge clk) begin
    if (rst) begin
        rst_d <= 1'b1;
        accept_hist <= '0;
        since_rst <= '0;
    end else begin
        rst_d <= 1'b0;
        accept_hist <= {accept_hist[1:0], inst_valid_i && inst_ready_o};
        if (since_rst != 2'd3) begin
            since_rst <= since_rst + 2'd1;
        end
    end
end

// --------------------
ready_in_reset: assert property (@(posedge clk) (rst && rst_d) |-> !inst_ready_o)
    else begin
        assert_failures++;
        $error("inst_ready_o high during reset");
    end

// retire exactly three edges after the accepting edge
retire_latency: assert property (@(posedge clk) disable iff (rst)
    retire_valid_o == accept_hist[2])
    else begin
        assert_failures++;
        $error("retire_valid_o does not follow an accepted instruction by 3 edges");
    end

quiet_after_reset: assert property (@(posedge clk)
    (!rst && since_rst != 2'd3) |-> !retire_valid_o)
    else begin
        assert_failures++;
        $error("retire_valid_o high right after reset");
    end

no_x0_write: assert property (@(posedge clk) disable iff (rst)
    (retire_valid_o && retire_o.we) |-> (retire_o.rd != '0))
    else begin
        assert_failures++;
        $error("retire write enable set for x0");
    end

endmodule

bind rv_core rv_core_checker checker0 (
    .clk            (clk),
    .rst            (rst),
    .inst_valid_i   (inst_valid_i),
    .inst_ready_o   (inst_ready_o),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o)
);

//--- rv_core_golden.txt
# instruction we rd data, all hex, one instruction per line
# data of a minstret read equals the number of lines before it
00500093 1 01 00000005
ffd00113 1 02 fffffffd
123451b7 1 03 12345000
6781e213 1 04 12345678
0f027293 1 05 00000070
0ff14313 1 06 ffffff02
00012393 1 07 00000001
00113413 1 08 00000000
00409493 1 09 00000050
01c15513 1 0a 0000000f
40115593 1 0b fffffffe
b0202673 1 0c 0000000b
004086b3 1 0d 1234567d
40168733 1 0e 12345678
00d747b3 1 0f 00000005
00f71833 1 10 468acf00
00f858b3 1 11 02345678
40115933 1 12 ffffffff
001929b3 1 13 00000001
0129ba33 1 14 00000001
011a7ab3 1 15 00000000
010aeb33 1 16 468acf00
00708013 0 00 00000000
00100bb3 1 17 00000005
00000fff 0 1f 00000000
00000c33 1 18 00000000
b0202cf3 1 19 0000001a
b0202d73 1 1a 0000001b
001d0d93 1 1b 0000001c
41b00e33 1 1c ffffffe4
fffffeb7 1 1d fffff000
fffe8e93 1 1d ffffefff
b0202f73 1 1e 00000020

//--- rv_core_macros.svh
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// --------------------
// widths
`define ARCH_WIDTH 32
`define RF_ADDR_WIDTH 5

// DEC, EXE, WBK
`define PIPE_STAGES 3

// --------------------
// major opcodes
`define OPC_OP 7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_LUI 7'b0110111
`define OPC_SYSTEM 7'b1110011

// retired instruction counter
`define CSR_MINSTRET 12'hB02

`endif

//--- rv_core_pkg.sv
`include "rv_core_macros.svh"

package rv_core_pkg;

// --------------------
// plain vectors
typedef logic [`ARCH_WIDTH-1:0] arch_width_t;
typedef logic [`ARCH_WIDTH-1:0] inst_width_t;
typedef logic [`RF_ADDR_WIDTH-1:0] rf_addr_t;

// --------------------
// selectors
typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU
} alu_op_t;

typedef enum logic {
    B_SEL_RS2,
    B_SEL_IMM
} b_sel_t;

typedef enum logic [1:0] {
    E_RES_SEL_ALU,
    E_RES_SEL_IMM_U,
    E_RES_SEL_CSR
} e_res_sel_t;

// --------------------
// stage payloads
typedef struct packed {
    alu_op_t alu_op;
    b_sel_t b_sel;
    e_res_sel_t e_res_sel;
    logic rd_we;
    rf_addr_t rs1;
    rf_addr_t rs2;
    rf_addr_t rd;
    arch_width_t imm;
} decoded_t;

typedef struct packed {
    logic valid;
    decoded_t decoded;
    arch_width_t op_a;
    arch_width_t op_b;
} exe_stage_t;

// WBK register and retire port
typedef struct packed {
    rf_addr_t rd;
    logic we;
    arch_width_t data;
} retire_t;

endpackage

//--- rv_decoder.sv
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module rv_decoder
    import rv_core_pkg::*;
(
    input  inst_width_t inst_i,
    output decoded_t    decoded_o
);

logic [6:0] opcode;
logic [2:0] funct3;
logic [6:0] funct7;
logic [11:0] csr_addr;
arch_width_t imm_i;
arch_width_t imm_u;
alu_op_t alu_op;
logic funct7_ok;
logic known;

assign opcode = inst_i[6:0];
assign funct3 = inst_i[14:12];
assign funct7 = inst_i[31:25];
assign csr_addr = inst_i[31:20];

// sign extended I, upper U
assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
assign imm_u = {inst_i[31:12], 12'h000};

// same funct3 map for both ALU forms, SUB only with a register operand
always_comb begin
    case (funct3)
        3'b000: alu_op = (opcode == `OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
        3'b001: alu_op = ALU_SLL;
        3'b010: alu_op = ALU_SLT;
        3'b011: alu_op = ALU_SLTU;
        3'b100: alu_op = ALU_XOR;
        3'b101: alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
        3'b110: alu_op = ALU_OR;
        default: alu_op = ALU_AND;
    endcase
end

// funct7 only constrained where the encoding defines it
always_comb begin
    funct7_ok = 1'b1;
    if (opcode == `OPC_OP) begin
        funct7_ok = (funct7 == 7'b0000000) ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
    end else if (funct3 == 3'b001) begin
        funct7_ok = (funct7 == 7'b0000000);
    end else if (funct3 == 3'b101) begin
        funct7_ok = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
    end
end

always_comb begin
    decoded_o.alu_op = alu_op;
    decoded_o.b_sel = B_SEL_RS2;
    decoded_o.e_res_sel = E_RES_SEL_ALU;
    decoded_o.rs1 = inst_i[19:15];
    decoded_o.rs2 = inst_i[24:20];
    decoded_o.rd = inst_i[11:7];
    decoded_o.imm = imm_i;
    case (opcode)
        `OPC_OP: known = funct7_ok;
        `OPC_OP_IMM: begin
            decoded_o.b_sel = B_SEL_IMM;
            known = funct7_ok;
        end
        `OPC_LUI: begin
            decoded_o.b_sel = B_SEL_IMM;
            decoded_o.e_res_sel = E_RES_SEL_IMM_U;
            decoded_o.imm = imm_u;
            known = 1'b1;
        end
        `OPC_SYSTEM: begin
            // csrrs rd, minstret, x0 only
            decoded_o.b_sel = B_SEL_IMM;
            decoded_o.e_res_sel = E_RES_SEL_CSR;
            known = (funct3 == 3'b010) && (inst_i[19:15] == '0) &&
                    (csr_addr == `CSR_MINSTRET);
        end
        default: known = 1'b0;
    endcase
    // unknown and x0 targets still retire, just without a write
    decoded_o.rd_we = known && (decoded_o.rd != '0);
end

endmodule

//--- rv_execute.sv
`timescale 1ns/1ps

module rv_execute
    import rv_core_pkg::*;
(
    input  exe_stage_t  stage_i,
    input  retire_t     wbk_i,
    input  logic        wbk_valid_i,
    input  arch_width_t csr_data_i,
    output retire_t     result_o
);

decoded_t dec;
logic fwd_a;
logic fwd_b;
arch_width_t op_a;
arch_width_t op_b;
logic [4:0] shamt;
arch_width_t alu_out;
arch_width_t res;

assign dec = stage_i.decoded;

// --------------------
// forwarding from WBK
assign fwd_a = wbk_valid_i && wbk_i.we && (wbk_i.rd == dec.rs1);
assign fwd_b = wbk_valid_i && wbk_i.we && (wbk_i.rd == dec.rs2) &&
               (dec.b_sel == B_SEL_RS2);

assign op_a = fwd_a ? wbk_i.data : stage_i.op_a;
assign op_b = fwd_b ? wbk_i.data : stage_i.op_b;

// --------------------
// ALU
assign shamt = op_b[4:0];

always_comb begin
    case (dec.alu_op)
        ALU_ADD: alu_out = op_a + op_b;
        ALU_SUB: alu_out = op_a - op_b;
        ALU_AND: alu_out = op_a & op_b;
        ALU_OR: alu_out = op_a | op_b;
        ALU_XOR: alu_out = op_a ^ op_b;
        ALU_SLL: alu_out = op_a << shamt;
        ALU_SRL: alu_out = op_a >> shamt;
        ALU_SRA: alu_out = arch_width_t'($signed(op_a) >>> shamt);
        ALU_SLT: alu_out = arch_width_t'($signed(op_a) < $signed(op_b));
        ALU_SLTU: alu_out = arch_width_t'(op_a < op_b);
        default: alu_out = '0;
    endcase
end

// --------------------
// result select
always_comb begin
    case (dec.e_res_sel)
        E_RES_SEL_IMM_U: res = dec.imm;
        E_RES_SEL_CSR: res = csr_data_i;
        default: res = alu_out;
    endcase
end

// a bubble never writes
assign result_o = '{
    rd: dec.rd,
    we: stage_i.valid && dec.rd_we,
    data: res
};

endmodule

//--- rv_reg_file.sv
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module rv_reg_file
    import rv_core_pkg::*;
(
    input  logic        clk,
    input  rf_addr_t    rs1_i,
    input  rf_addr_t    rs2_i,
    input  retire_t     wr_i,
    input  logic        wr_valid_i,
    output arch_width_t rs1_data_o,
    output arch_width_t rs2_data_o
);

// x0 has no storage
arch_width_t regs [1:(1 << `RF_ADDR_WIDTH) - 1];
logic wr_en;

assign wr_en = wr_valid_i && wr_i.we && (wr_i.rd != '0);

always_ff @(posedge clk) begin
    if (wr_en) begin
        regs[wr_i.rd] <= wr_i.data;
    end
end

// write-through so DEC sees the value WBK is writing this cycle
function automatic arch_width_t read_port(input rf_addr_t addr);
    if (addr == '0) return '0;
    if (wr_en && (addr == wr_i.rd)) return wr_i.data;
    return regs[addr];
endfunction

always_comb begin
    rs1_data_o = read_port(rs1_i);
    rs2_data_o = read_port(rs2_i);
end

endmodule

//--- rv_retire_counter.sv
`timescale 1ns/1ps

module rv_retire_counter
    import rv_core_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        retire_valid_i,
    output arch_width_t count_o
);

arch_width_t count_q;

// minstret
always_ff @(posedge clk) begin
    if (rst) begin
        count_q <= '0;
    end else if (retire_valid_i) begin
        count_q <= count_q + 1'b1;
    end
end

// include the instruction leaving WBK this cycle,
// it is older than whatever reads the CSR in EXE
assign count_o = count_q + arch_width_t'(retire_valid_i);

endmodule

//--- tb.f
+incdir+.
rv_core_pkg.sv
rv_decoder.sv
rv_reg_file.sv
rv_execute.sv
rv_retire_counter.sv
rv_core.sv
rv_core_checker.sv
tb_clock_gen.sv
tb_rv_core.sv

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

// 4 ns period
initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
end

// reset held for 4 rising edges
initial begin
    rst_o = 1'b1;
    repeat (4) @(posedge clk_o);
    rst_o <= 1'b0;
end

endmodule

//--- tb_rv_core.sv
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module tb_rv_core
    import rv_core_pkg::*;
();

localparam int RESET_MARGIN = 40;

typedef struct packed {
    retire_t ret;
    logic is_csr;
} expect_t;

logic clk;
logic rst;
logic inst_valid_i;
inst_width_t inst_i;
logic inst_ready_o;
logic retire_valid_o;
retire_t retire_o;

inst_width_t stim_q [$];
expect_t golden_q [$];
expect_t inflight_q [$];
int value_errors = 0;
int other_errors = 0;
int retired = 0;
logic [31:0] lcg_state = 32'h2001c346;
logic loaded = 1'b0;

tb_clock_gen clock_gen0 (
    .clk_o (clk),
    .rst_o (rst)
);

rv_core dut0 (
    .clk            (clk),
    .rst            (rst),
    .inst_valid_i   (inst_valid_i),
    .inst_i         (inst_i),
    .inst_ready_o   (inst_ready_o),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o)
);

// --------------------
// helpers
function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

function automatic logic is_minstret_read(input inst_width_t inst);
    return (inst[6:0] == `OPC_SYSTEM) && (inst[14:12] == 3'b010) &&
           (inst[31:20] == `CSR_MINSTRET);
endfunction

// data only matters when the write is enabled
task automatic check_retire(input retire_t expected, input retire_t actual);
    if (actual.we !== expected.we || actual.rd !== expected.rd ||
        (expected.we && actual.data !== expected.data)) begin
        value_errors++;
        $display("FAILED retire_o: expected rd=%h we=%h data=%h, got rd=%h we=%h data=%h",
                 expected.rd, expected.we, expected.data,
                 actual.rd, actual.we, actual.data);
    end
endtask

task automatic check_ready(input logic expected, input logic actual);
    if (actual !== expected) begin
        value_errors++;
        $display("FAILED inst_ready_o: expected %h, got %h", expected, actual);
    end
endtask

// columns: instruction, we, rd, data
task automatic load_golden();
    int fd;
    int code;
    int idx;
    string line;
    logic [31:0] f_inst;
    logic [31:0] f_we;
    logic [31:0] f_rd;
    logic [31:0] f_data;
    expect_t e;
    fd = $fopen("rv_core_golden.txt", "r");
    if (fd == 0) begin
        other_errors++;
        $display("could not open rv_core_golden.txt");
        return;
    end
    idx = 0;
    while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
            code = $sscanf(line, "%h %h %h %h", f_inst, f_we, f_rd, f_data);
            if (code == 4) begin
                e.ret.rd = f_rd[4:0];
                e.ret.we = f_we[0];
                e.ret.data = f_data;
                e.is_csr = is_minstret_read(f_inst);
                // a minstret read sees every instruction before it
                if (e.is_csr && f_data != 32'(idx)) begin
                    other_errors++;
                    $display("golden line %0d holds minstret %h but %0d instructions precede it",
                             idx, f_data, idx);
                end
                stim_q.push_back(f_inst);
                golden_q.push_back(e);
                idx++;
            end else begin
                other_errors++;
                $display("golden file has a malformed line: %s", line);
            end
        end
    end
    $fclose(fd);
endtask

// --------------------
// stimulus
initial begin
    logic [31:0] rnd;
    int gap;
    inst_valid_i = 1'b0;
    inst_i = '0;
    load_golden();
    loaded = 1'b1;
    @(posedge clk);
    while (rst) begin
        @(posedge clk);
        check_ready(1'b0, inst_ready_o);
        if (retire_valid_o) begin
            other_errors++;
            $display("retire_valid_o went high during reset");
        end
    end
    // ready stays low a few cycles past reset
    repeat (`PIPE_STAGES - 1) begin
        @(posedge clk);
        check_ready(1'b0, inst_ready_o);
    end
    // and is up on the next edge
    @(posedge clk);
    check_ready(1'b1, inst_ready_o);
    for (int i = 0; i < stim_q.size(); i++) begin
        rnd = lcg_next();
        gap = int'(rnd[17:16]);
        repeat (gap) begin
            inst_valid_i <= 1'b0;
            @(posedge clk);
        end
        inst_valid_i <= 1'b1;
        inst_i <= stim_q[i];
        do begin
            @(posedge clk);
            check_ready(1'b1, inst_ready_o);
        end while (!inst_ready_o);
        inflight_q.push_back(golden_q[i]);
    end
    inst_valid_i <= 1'b0;
    while (inflight_q.size() != 0) begin
        @(posedge clk);
    end
    repeat (4) @(posedge clk);
    if (retired != stim_q.size()) begin
        other_errors++;
        $display("retired %0d instructions, sent %0d", retired, stim_q.size());
    end
    $display("errors: %0d value, %0d other, %0d assertion; %0d retired",
             value_errors, other_errors, dut0.checker0.assert_failures, retired);
    if (value_errors == 0 && other_errors == 0 && dut0.checker0.assert_failures == 0) begin
        $display("Regression passed");
    end else begin
        $display("Regression failed");
    end
    $finish;
end

// --------------------
// retire monitor
always @(posedge clk) begin
    expect_t e;
    if (!rst && retire_valid_o) begin
        if (inflight_q.size() == 0) begin
            other_errors++;
            $display("retire seen with nothing in flight, rd=%h", retire_o.rd);
        end else begin
            e = inflight_q.pop_front();
            if (e.is_csr && e.ret.data != 32'(retired)) begin
                other_errors++;
                $display("minstret read expects %h but %0d have retired", e.ret.data, retired);
            end
            check_retire(e.ret, retire_o);
        end
        retired++;
    end
end

// watchdog, 5 cycles per instruction plus reset
initial begin
    int limit_ns;
    wait (loaded);
    limit_ns = (stim_q.size() * 5 + RESET_MARGIN) * 4;
    #(limit_ns * 1ns);
    $display("timeout: run did not finish within %0d ns", limit_ns);
    $display("Regression failed");
    $finish;
end

endmodule
